//--- compile.f
stony_pkg.sv
stony_pin_if.sv
stony_write_if.sv
stony_pulse_driver.sv
stony_reg_writer.sv
stony_sequencer.sv
stony_ctrl.sv
stony_ctrl_sva.sv
tb_stony_ctrl.sv

//--- tb_stony_ctrl.sv
/* Testbench for the image sensor controller: random settings, two masked
   frame scans, a pin-level sensor model and an ADC responder */
`timescale 1ns/1ps

module tb_stony_ctrl import stony_pkg::*; ();

    logic              clk;
    logic              reset;
    logic              frame_capture_start;
    logic              adc_capture_done;
    logic              mask_capture_pixel;
    logic [val_w-1:0]  vsw_value;
    logic [val_w-1:0]  hsw_value;
    logic [bias_w-1:0] vref_value;
    logic [bias_w-1:0] config_value;
    logic [bias_w-1:0] nbias_value;
    logic [bias_w-1:0] aobias_value;
    logic              controller_busy;
    logic              frame_capture_done;
    logic              adc_capture_start;
    logic [addr_w-1:0] mask_pixel_row;
    logic [addr_w-1:0] mask_pixel_col;
    logic              resp;
    logic              incp;
    logic              resv;
    logic              incv;

    int               seed = 85591;
    int               mask_seed = 0;
    int               adc_delay = -1;
    logic             adc_wait = 1'b0;
    logic             prev_busy = 1'b1;
    logic             init_seen = 1'b0;
    int               lin;
    int               prev_lin = 0;
    int               start_count = 0;
    int               expected_starts = 0;
    int               done_count = 0;
    int               scan_steps = 0;
    logic [ptr_w-1:0] sens_ptr;
    logic [val_w-1:0] sens_reg [8];

    stony_ctrl stony_ctrl_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1, "stopped at first error");
    endtask

    // Roughly a third of the pixels, different per frame
    function automatic logic pixel_masked(input int row, input int col, input int mseed);
        int h;
        h = ((row * 131) + (col * 71)) ^ (mseed & 'hffff);
        h = h ^ (h >> 3);
        return (h % 3) == 0;
    endfunction

    task automatic wait_busy(input logic level, input int limit, input string what);
        int n;
        n = 0;
        while (controller_busy !== level) begin
            @(posedge clk);
            n++;
            if (n > limit) begin
                fail_now($sformatf("Timeout after %0d cycles waiting for %s", limit, what));
            end
        end
    endtask

    task automatic check_reg(input int idx, input int expected, input string name);
        assert (sens_reg[idx] === expected[val_w-1:0])
        else fail_now($sformatf("mismatch at %0t: %s register is %0d, expected %0d",
                                $time, name, sens_reg[idx], expected));
    endtask

    //////////////////////////////
    // Sensor model and responders
    //////////////////////////////

    always @(posedge clk) begin
        if (resp) sens_ptr = '0;
        if (incp) sens_ptr = sens_ptr + 1'b1;
        if (resv) sens_reg[sens_ptr] = '0;
        if (incv) sens_reg[sens_ptr] = sens_reg[sens_ptr] + 1'b1;

        mask_capture_pixel <= pixel_masked(mask_pixel_row, mask_pixel_col, mask_seed);

        if (adc_capture_done) adc_wait = 1'b0;
        if (adc_capture_start) begin
            assert (!adc_wait)
            else fail_now($sformatf("mismatch at %0t: adc_capture_start before adc done", $time));
            assert (sens_reg[rowsel_ptr] == mask_pixel_row &&
                    sens_reg[colsel_ptr] == mask_pixel_col)
            else fail_now($sformatf("mismatch at %0t: sensor at %0d,%0d, mask address %0d,%0d",
                                    $time, sens_reg[rowsel_ptr], sens_reg[colsel_ptr],
                                    mask_pixel_row, mask_pixel_col));
            assert (pixel_masked(mask_pixel_row, mask_pixel_col, mask_seed))
            else fail_now($sformatf("mismatch at %0t: ADC started on unmasked pixel", $time));
            start_count++;
            adc_wait = 1'b1;
            adc_delay = $unsigned($random(seed)) % 6;
        end

        // ADC finishes 0 to 5 cycles after the start
        adc_capture_done <= 1'b0;
        if (adc_delay == 0) adc_capture_done <= 1'b1;
        if (adc_delay >= 0) adc_delay--;

        // Row-major scan, wrapping to 0 only at the frame end
        lin = mask_pixel_row * col_resolution + mask_pixel_col;
        if (lin != prev_lin) begin
            assert (lin == (prev_lin + 1) % (row_resolution * col_resolution))
            else fail_now($sformatf("mismatch at %0t: mask address jumped from %0d to %0d",
                                    $time, prev_lin, lin));
            assert (frame_capture_done == (lin == 0))
            else fail_now($sformatf("mismatch at %0t: frame done and scan wrap disagree", $time));
            scan_steps++;
            prev_lin = lin;
        end

        if (init_seen) begin
            assert (frame_capture_done == (prev_busy && !controller_busy))
            else fail_now($sformatf("mismatch at %0t: busy fall and frame done disagree", $time));
        end else if (prev_busy && !controller_busy) begin
            init_seen = 1'b1;
        end
        if (frame_capture_done) done_count++;
        prev_busy = controller_busy;

        // Pulse and strobe rules watched by the bound checker
        assert (stony_ctrl_i.stony_ctrl_sva_i.error_count == 0)
        else fail_now($sformatf("A bound pin or ADC strobe assertion failed before %0t",
                                $time));
    end

    task automatic run_frame(input int frame);
        mask_seed = $random(seed);
        for (int r = 0; r < row_resolution; r++) begin
            for (int c = 0; c < col_resolution; c++) begin
                if (pixel_masked(r, c, mask_seed)) expected_starts++;
            end
        end
        @(posedge clk);
        frame_capture_start <= 1'b1;
        @(posedge clk);
        frame_capture_start <= 1'b0;
        wait_busy(1'b1, 10, "the capture to start");
        wait_busy(1'b0, 400000, "the frame capture to finish");
        @(posedge clk);
        assert (done_count == frame)
        else fail_now($sformatf("mismatch at %0t: %0d frame done pulses after frame %0d",
                                $time, done_count, frame));
        assert (start_count == expected_starts)
        else fail_now($sformatf("mismatch at %0t: %0d ADC starts, expected %0d",
                                $time, start_count, expected_starts));
        assert (scan_steps == frame * row_resolution * col_resolution)
        else fail_now($sformatf("mismatch at %0t: %0d scan steps", $time, scan_steps));
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        reset               = 1'b1;
        frame_capture_start = 1'b0;
        adc_capture_done    = 1'b0;
        mask_capture_pixel  = 1'b0;
        vsw_value           = '0;
        hsw_value           = '0;
        vref_value          = '0;
        config_value        = '0;
        nbias_value         = '0;
        aobias_value        = '0;
        @(posedge clk);
        vsw_value    <= $random(seed);
        hsw_value    <= $random(seed);
        vref_value   <= $random(seed);
        config_value <= $random(seed);
        nbias_value  <= $random(seed);
        aobias_value <= $random(seed);
        repeat (7) @(posedge clk);
        reset <= 1'b0;

        wait_busy(1'b0, 20000, "sensor programming to finish");
        @(posedge clk);
        check_reg(colsel_ptr, 0, "column");
        check_reg(rowsel_ptr, 0, "row");
        check_reg(vsw_ptr, vsw_value, "vsw");
        check_reg(hsw_ptr, hsw_value, "hsw");
        check_reg(vref_ptr, vref_value, "vref");
        check_reg(nbias_ptr, nbias_value, "nbias");
        check_reg(aobias_ptr, aobias_value, "aobias");
        check_reg(config_ptr, config_value, "config");

        run_frame(1);
        run_frame(2);

        if (stony_ctrl_i.stony_ctrl_sva_i.error_count == 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            $display("A bound pin or ADC strobe assertion failed in the last cycle");
            $display("Test failures found");
            $fatal(1, "bound assertion failed");
        end
    end

endmodule

//--- stony_ctrl_sva.sv
/* Bound checks on the sensor pin pulses and the ADC strobe; attached to
   the controller top level by the bind at the end */
`timescale 1ns/1ps

module stony_ctrl_sva (
    input logic clk,
    input logic reset,
    input logic resp,
    input logic incp,
    input logic resv,
    input logic incv,
    input logic adc_capture_start,
    input logic adc_capture_done
);

    logic any_pin;
    logic adc_wait;
    int   error_count = 0;

    assign any_pin = resp | incp | resv | incv;

    // High from the cycle after the ADC start until done is seen
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            adc_wait <= 1'b0;
        end else if (adc_capture_start) begin
            adc_wait <= 1'b1;
        end else if (adc_capture_done) begin
            adc_wait <= 1'b0;
        end
    end

    one_pin_at_a_time: assert property (@(posedge clk) disable iff (reset)
        $onehot0({resp, incp, resv, incv}))
        else begin
            $error("more than one sensor pin high");
            error_count++;
        end

    pin_pulse_one_cycle: assert property (@(posedge clk) disable iff (reset)
        any_pin |=> !any_pin)
        else begin
            $error("sensor pin pulse longer than one cycle");
            error_count++;
        end

    adc_start_single: assert property (@(posedge clk) disable iff (reset)
        adc_capture_start |=> !adc_capture_start)
        else begin
            $error("adc_capture_start high in two consecutive cycles");
            error_count++;
        end

    pins_still_during_adc: assert property (@(posedge clk) disable iff (reset)
        adc_wait |-> !any_pin)
        else begin
            $error("sensor pin pulsed while the ADC was running");
            error_count++;
        end

endmodule

bind stony_ctrl stony_ctrl_sva stony_ctrl_sva_i (
    .clk              (clk),
    .reset            (reset),
    .resp             (resp),
    .incp             (incp),
    .resv             (resv),
    .incv             (incv),
    .adc_capture_start(adc_capture_start),
    .adc_capture_done (adc_capture_done)
);

//--- stony_ctrl.sv
/* Top level of the image sensor controller; connects the sequencer,
   register writer and pulse driver to the sensor pins and user ports */
`timescale 1ns/1ps

module stony_ctrl import stony_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              frame_capture_start,
    input  logic              adc_capture_done,
    input  logic              mask_capture_pixel,
    input  logic [val_w-1:0]  vsw_value,
    input  logic [val_w-1:0]  hsw_value,
    input  logic [bias_w-1:0] vref_value,
    input  logic [bias_w-1:0] config_value,
    input  logic [bias_w-1:0] nbias_value,
    input  logic [bias_w-1:0] aobias_value,
    output logic              controller_busy,
    output logic              frame_capture_done,
    output logic              adc_capture_start,
    output logic [addr_w-1:0] mask_pixel_row,
    output logic [addr_w-1:0] mask_pixel_col,
    output logic              resp,
    output logic              incp,
    output logic              resv,
    output logic              incv
);

    stony_write_if wr_if ();
    stony_pin_if   pin_if ();

    stony_sequencer sequencer_i (
        .clk                (clk),
        .reset              (reset),
        .frame_capture_start(frame_capture_start),
        .adc_capture_done   (adc_capture_done),
        .mask_capture_pixel (mask_capture_pixel),
        .vsw_value          (vsw_value),
        .hsw_value          (hsw_value),
        .vref_value         (vref_value),
        .config_value       (config_value),
        .nbias_value        (nbias_value),
        .aobias_value       (aobias_value),
        .wr                 (wr_if.seq),
        .controller_busy    (controller_busy),
        .frame_capture_done (frame_capture_done),
        .adc_capture_start  (adc_capture_start),
        .mask_pixel_row     (mask_pixel_row),
        .mask_pixel_col     (mask_pixel_col)
    );

    stony_reg_writer reg_writer_i (
        .clk  (clk),
        .reset(reset),
        .wr   (wr_if.writer),
        .pin  (pin_if.writer)
    );

    stony_pulse_driver pulse_driver_i (
        .clk  (clk),
        .reset(reset),
        .pin  (pin_if.driver),
        .resp (resp),
        .incp (incp),
        .resv (resv),
        .incv (incv)
    );

endmodule

//--- stony_sequencer.sv
/* Main controller FSM: programs the sensor registers after reset, then
   scans every pixel of a frame and runs the ADC for the masked ones */
`timescale 1ns/1ps

module stony_sequencer import stony_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic                frame_capture_start,
    input  logic                adc_capture_done,
    input  logic                mask_capture_pixel,
    input  logic [val_w-1:0]    vsw_value,
    input  logic [val_w-1:0]    hsw_value,
    input  logic [bias_w-1:0]   vref_value,
    input  logic [bias_w-1:0]   config_value,
    input  logic [bias_w-1:0]   nbias_value,
    input  logic [bias_w-1:0]   aobias_value,
    stony_write_if.seq          wr,
    output logic                controller_busy,
    output logic                frame_capture_done,
    output logic                adc_capture_start,
    output logic [addr_w-1:0]   mask_pixel_row,
    output logic [addr_w-1:0]   mask_pixel_col
);

    logic [seq_state_w-1:0] state;
    logic [init_step_w-1:0] init_step;
    logic                   val_phase;
    logic [1:0]             cap_step;
    logic                   wait_wr;
    logic [ptr_w-1:0]       init_ptr;
    logic [val_w-1:0]       init_val;
    logic                   pixel_finish;
    logic                   last_col;
    logic                   last_row;

    assign controller_busy = (state != st_idle);
    assign last_col = (mask_pixel_col == addr_w'(col_resolution - 1));
    assign last_row = (mask_pixel_row == addr_w'(row_resolution - 1));

    // Pixel ends when its column is reached unmasked, or when the ADC is done
    assign pixel_finish = (state == st_cap && cap_step == cap_col_val && wait_wr &&
                           wr.done && !mask_capture_pixel) ||
                          (state == st_adc && adc_capture_done);

    //////////////////////////////
    // Request contents
    //////////////////////////////

    // Step 0 only clears the pointer
    always_comb begin
        init_ptr = colsel_ptr;
        init_val = '0;
        case (init_step)
            4'd2: init_ptr = rowsel_ptr;
            4'd3: begin
                init_ptr = vsw_ptr;
                init_val = vsw_value;
            end
            4'd4: begin
                init_ptr = hsw_ptr;
                init_val = hsw_value;
            end
            4'd5: begin
                init_ptr = vref_ptr;
                init_val = {{(val_w-bias_w){1'b0}}, vref_value};
            end
            4'd6: begin
                init_ptr = nbias_ptr;
                init_val = {{(val_w-bias_w){1'b0}}, nbias_value};
            end
            4'd7: begin
                init_ptr = aobias_ptr;
                init_val = {{(val_w-bias_w){1'b0}}, aobias_value};
            end
            4'd8: begin
                init_ptr = config_ptr;
                init_val = {{(val_w-bias_w){1'b0}}, config_value};
            end
            default: ;
        endcase
    end

    always_comb begin
        wr.sel_ptr     = !cap_step[0];
        wr.clear_first = 1'b0;
        case (cap_step)
            cap_row_ptr: wr.target = {{(val_w-ptr_w){1'b0}}, rowsel_ptr};
            cap_row_val: wr.target = {{(val_w-addr_w){1'b0}}, mask_pixel_row};
            cap_col_ptr: wr.target = {{(val_w-ptr_w){1'b0}}, colsel_ptr};
            default:     wr.target = {{(val_w-addr_w){1'b0}}, mask_pixel_col};
        endcase
        if (state == st_init) begin
            wr.sel_ptr     = !val_phase;
            wr.clear_first = val_phase || (init_step == '0);
            wr.target      = val_phase ? init_val : {{(val_w-ptr_w){1'b0}}, init_ptr};
        end
    end

    //////////////////////////////
    // Main FSM
    //////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state              <= st_init;
            init_step          <= '0;
            val_phase          <= 1'b0;
            cap_step           <= cap_row_ptr;
            wait_wr            <= 1'b0;
            wr.req             <= 1'b0;
            frame_capture_done <= 1'b0;
            adc_capture_start  <= 1'b0;
            mask_pixel_row     <= '0;
            mask_pixel_col     <= '0;
        end else begin
            wr.req             <= 1'b0;
            frame_capture_done <= 1'b0;
            adc_capture_start  <= 1'b0;
            case (state)
                st_init: begin
                    if (!wait_wr) begin
                        wr.req  <= 1'b1;
                        wait_wr <= 1'b1;
                    end else if (wr.done) begin
                        wait_wr <= 1'b0;
                        if (val_phase || init_step == '0) begin
                            val_phase <= 1'b0;
                            init_step <= init_step + 1'b1;
                            if (init_step == init_last_step) begin
                                state <= st_idle;
                            end
                        end else begin
                            val_phase <= 1'b1;
                        end
                    end
                end
                st_idle: begin
                    if (frame_capture_start) begin
                        mask_pixel_row <= '0;
                        mask_pixel_col <= '0;
                        cap_step       <= cap_row_ptr;
                        state          <= st_cap;
                    end
                end
                st_cap: begin
                    if (!wait_wr) begin
                        wr.req  <= 1'b1;
                        wait_wr <= 1'b1;
                    end else if (wr.done) begin
                        wait_wr <= 1'b0;
                        if (cap_step != cap_col_val) begin
                            cap_step <= cap_step + 1'b1;
                        end else if (mask_capture_pixel) begin
                            adc_capture_start <= 1'b1;
                            state             <= st_adc;
                        end
                    end
                end
                // ADC wait ends through the pixel step below
                default: ;
            endcase

            // Next pixel, staying on the column pointer within a row
            if (pixel_finish) begin
                state <= st_cap;
                if (!last_col) begin
                    mask_pixel_col <= mask_pixel_col + 1'b1;
                    cap_step       <= cap_col_val;
                end else if (!last_row) begin
                    mask_pixel_col <= '0;
                    mask_pixel_row <= mask_pixel_row + 1'b1;
                    cap_step       <= cap_row_ptr;
                end else begin
                    mask_pixel_col     <= '0;
                    mask_pixel_row     <= '0;
                    frame_capture_done <= 1'b1;
                    state              <= st_idle;
                end
            end
        end
    end

endmodule

//--- stony_reg_writer.sv
/* Walks the sensor pointer or the selected register to a target value
   using only clear and increment pulses, then strobes done */
`timescale 1ns/1ps

module stony_reg_writer import stony_pkg::*; (
    input  logic clk,
    input  logic reset,
    stony_write_if.writer wr,
    stony_pin_if.writer   pin
);

    logic                 active;
    logic [val_w-1:0]     cur;
    logic                 at_target;
    logic                 above;
    logic [pin_cmd_w-1:0] clr_cmd;
    logic [pin_cmd_w-1:0] inc_cmd;
    logic                 start;
    logic                 decide;
    logic                 issue;
    logic                 finish;

    // Compare against the shadow of whatever is being moved
    assign cur       = wr.sel_ptr ? {{(val_w-ptr_w){1'b0}}, pin.ptr} : pin.cur_val;
    assign at_target = (cur == wr.target);
    assign above     = (cur > wr.target);
    assign clr_cmd   = wr.sel_ptr ? cmd_resp : cmd_resv;
    assign inc_cmd   = wr.sel_ptr ? cmd_incp : cmd_incv;

    // A decision happens on a plain request or after each ack
    assign start  = !active && wr.req;
    assign decide = (start && !wr.clear_first) || (active && pin.ack);
    assign issue  = (start && wr.clear_first) || (decide && !at_target);
    assign finish = decide && at_target;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            active        <= 1'b0;
            pin.cmd_valid <= 1'b0;
            wr.done       <= 1'b0;
        end else begin
            pin.cmd_valid <= issue;
            wr.done       <= finish;
            if (finish) begin
                active <= 1'b0;
            end else if (start) begin
                active <= 1'b1;
            end
        end
    end

    // Above the target needs a clear, the increments follow
    always_ff @(posedge clk) begin
        if (issue) begin
            if ((start && wr.clear_first) || above) begin
                pin.cmd <= clr_cmd;
            end else begin
                pin.cmd <= inc_cmd;
            end
        end
    end

endmodule

//--- stony_pulse_driver.sv
/* Fires one sensor pin per command and mirrors the sensor's pointer and
   registers, so the writer can see where the sensor stands */
`timescale 1ns/1ps

module stony_pulse_driver import stony_pkg::*; (
    input  logic clk,
    input  logic reset,
    stony_pin_if.driver pin,
    output logic resp,
    output logic incp,
    output logic resv,
    output logic incv
);

    logic             phase;
    logic [ptr_w-1:0] ptr;
    logic [val_w-1:0] shadow [2**ptr_w];

    assign pin.ptr     = ptr;
    assign pin.cur_val = shadow[ptr];

    //////////////////////////////
    // Pin pulse and pointer
    //////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            phase   <= 1'b0;
            pin.ack <= 1'b0;
            ptr     <= '0;
            resp    <= 1'b0;
            incp    <= 1'b0;
            resv    <= 1'b0;
            incv    <= 1'b0;
        end else begin
            // First cycle raises the pin, second drops it and acks
            phase   <= pin.cmd_valid && !phase;
            pin.ack <= phase;
            resp    <= pin.cmd_valid && !phase && (pin.cmd == cmd_resp);
            incp    <= pin.cmd_valid && !phase && (pin.cmd == cmd_incp);
            resv    <= pin.cmd_valid && !phase && (pin.cmd == cmd_resv);
            incv    <= pin.cmd_valid && !phase && (pin.cmd == cmd_incv);
            if (phase) begin
                if (resp) begin
                    ptr <= '0;
                end else if (incp) begin
                    ptr <= ptr + 1'b1;
                end
            end
        end
    end

    //////////////////////////////
    // Register shadow
    //////////////////////////////

    // The pin still high in the second cycle says what to apply
    always_ff @(posedge clk) begin
        if (phase) begin
            if (resv) begin
                shadow[ptr] <= '0;
            end else if (incv) begin
                shadow[ptr] <= shadow[ptr] + 1'b1;
            end
        end
    end

endmodule

//--- stony_write_if.sv
/* Request path from the sequencer to the register writer; the sequencer
   holds the request fields from req until done */
`timescale 1ns/1ps

interface stony_write_if import stony_pkg::*; ();

    logic             req;
    logic             sel_ptr;
    logic             clear_first;
    logic [val_w-1:0] target;
    logic             done;

    // sel_ptr high targets the pointer, low the selected register
    modport seq    (output req, sel_ptr, clear_first, target, input done);
    modport writer (input req, sel_ptr, clear_first, target, output done);

endinterface

//--- stony_pin_if.sv
/* Command path from the register writer to the pulse driver, with the
   driver's shadow pointer and selected register value coming back */
`timescale 1ns/1ps

interface stony_pin_if import stony_pkg::*; ();

    logic                 cmd_valid;
    logic [pin_cmd_w-1:0] cmd;
    logic                 ack;
    logic [ptr_w-1:0]     ptr;
    logic [val_w-1:0]     cur_val;

    // One command in flight, acked two cycles after cmd_valid
    modport writer (output cmd_valid, cmd, input ack, ptr, cur_val);
    modport driver (input cmd_valid, cmd, output ack, ptr, cur_val);

endinterface

//--- stony_pkg.sv
/* Constants shared by the image sensor controller: sensor register map,
   pixel resolution, widths, pulse pin commands and FSM encodings */
package stony_pkg;

    // Widths
    localparam int ptr_w     = 3;
    localparam int val_w     = 8;
    localparam int addr_w    = 7;
    localparam int bias_w    = 6;
    localparam int pin_cmd_w = 2;

    // Sensor register indices
    localparam logic [ptr_w-1:0] colsel_ptr = 3'd0;
    localparam logic [ptr_w-1:0] rowsel_ptr = 3'd1;
    localparam logic [ptr_w-1:0] vsw_ptr    = 3'd2;
    localparam logic [ptr_w-1:0] hsw_ptr    = 3'd3;
    localparam logic [ptr_w-1:0] vref_ptr   = 3'd4;
    localparam logic [ptr_w-1:0] config_ptr = 3'd5;
    localparam logic [ptr_w-1:0] nbias_ptr  = 3'd6;
    localparam logic [ptr_w-1:0] aobias_ptr = 3'd7;

    localparam int row_resolution = 112;
    localparam int col_resolution = 112;

    // Which pin the pulse driver fires
    localparam logic [pin_cmd_w-1:0] cmd_resp = 2'd0;
    localparam logic [pin_cmd_w-1:0] cmd_incp = 2'd1;
    localparam logic [pin_cmd_w-1:0] cmd_resv = 2'd2;
    localparam logic [pin_cmd_w-1:0] cmd_incv = 2'd3;

    // Sequencer FSM
    localparam int seq_state_w = 2;
    localparam logic [seq_state_w-1:0] st_init = 2'd0;
    localparam logic [seq_state_w-1:0] st_idle = 2'd1;
    localparam logic [seq_state_w-1:0] st_cap  = 2'd2;
    localparam logic [seq_state_w-1:0] st_adc  = 2'd3;

    localparam int init_step_w = 4;
    localparam logic [init_step_w-1:0] init_last_step = 4'd8;

    // Capture steps, even steps move the pointer
    localparam logic [1:0] cap_row_ptr = 2'd0;
    localparam logic [1:0] cap_row_val = 2'd1;
    localparam logic [1:0] cap_col_ptr = 2'd2;
    localparam logic [1:0] cap_col_val = 2'd3;

endpackage
